//--- src.f
hdl/dcache_pkg.sv
hdl/cache_ram.sv
hdl/line_store_if.sv
hdl/cache_storage.sv
hdl/store_merge.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/dcache_assertions.sv
tests/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f src.f \
    && ./obj_dir/Vdcache_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log 2>/dev/null && exit 0 || exit 1

//--- tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_TXN   = 400;
    localparam int MAX_CYCLE = NUM_TXN * 40;

    logic              clk = 1'b0;
    logic              reset;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    word_t             req_wdata;
    strb_t             req_wstrb;
    logic              req_ready;
    logic              resp_valid;
    word_t             rdata;
    logic              mem_rd_req;
    logic [ADDR_W-1:0] mem_rd_addr;
    logic              mem_rd_rdy;
    logic              mem_ret_valid;
    line_t             mem_ret_data;
    logic              mem_wr_req;
    logic [ADDR_W-1:0] mem_wr_addr;
    line_t             mem_wr_data;
    logic              mem_wr_rdy;

    logic [31:0]       rng = 32'd12070;
    int                errors = 0;
    int                resp_count = 0;
    int                cycles = 0;
    logic [ADDR_W-1:0] cur_line;               // line of the request in flight
    word_t             golden [logic [31:0]];  // word addressed
    line_t             backing [logic [31:0]]; // line addressed

    dcache_top u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // untouched memory holds a pattern of its own address
    function automatic word_t fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t golden_word(input logic [31:0] addr);
        return golden.exists(addr) ? golden[addr] : fill_word(addr);
    endfunction

    function automatic line_t memory_line(input logic [31:0] line_addr);
        line_t l;
        if (backing.exists(line_addr)) begin
            return backing[line_addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = fill_word(line_addr + 32'(4 * w));
        end
        return l;
    endfunction

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected 0x%0h, got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("timeout: the cache did not finish %0d transactions in %0d cycles",
                     NUM_TXN, MAX_CYCLE);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!reset && resp_valid) begin
            resp_count++;
        end
    end

    ////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////
    initial begin
        int          wr_wait;
        int          rd_wait;
        int          ret_wait;
        logic        wr_armed;
        logic        rd_armed;
        logic        ret_pend;
        logic [31:0] ret_addr;
        logic        wr_rdy_n;
        logic        rd_rdy_n;
        logic        ret_n;
        mem_rd_rdy    = 1'b0;
        mem_wr_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        wr_armed      = 1'b0;
        rd_armed      = 1'b0;
        ret_pend      = 1'b0;
        ret_addr      = '0;
        forever begin
            @(negedge clk);
            wr_rdy_n = 1'b0;
            rd_rdy_n = 1'b0;
            ret_n    = 1'b0;
            if (mem_wr_req && mem_wr_rdy) begin  // write-back completes at next edge
                compare("mem_wr_addr offset", '0, mem_wr_addr[OFFSET_W-1:0]);
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    compare("mem_wr_data", golden_word(mem_wr_addr + 32'(4 * w)),
                            mem_wr_data[w]);
                end
                backing[mem_wr_addr] = mem_wr_data;
                wr_armed = 1'b0;
            end else if (mem_wr_req) begin
                if (!wr_armed) begin
                    wr_wait  = int'(next_random() % 4);
                    wr_armed = 1'b1;
                end
                if (wr_wait == 0) wr_rdy_n = 1'b1;
                else wr_wait--;
            end
            if (mem_rd_req && mem_rd_rdy) begin
                compare("mem_rd_addr", cur_line, mem_rd_addr);
                ret_addr = mem_rd_addr;
                ret_wait = int'(next_random() % 4);  // line back 1 to 4 cycles later
                ret_pend = 1'b1;
                rd_armed = 1'b0;
            end else if (mem_rd_req) begin
                if (!rd_armed) begin
                    rd_wait  = int'(next_random() % 4);
                    rd_armed = 1'b1;
                end
                if (rd_wait == 0) rd_rdy_n = 1'b1;
                else rd_wait--;
            end else if (ret_pend) begin
                if (ret_wait == 0) begin
                    ret_n    = 1'b1;
                    ret_pend = 1'b0;
                end else begin
                    ret_wait--;
                end
            end
            @(posedge clk);
            mem_wr_rdy    <= wr_rdy_n;
            mem_rd_rdy    <= rd_rdy_n;
            mem_ret_valid <= ret_n;
            mem_ret_data  <= memory_line(ret_addr);
        end
    end

    ////////////////////////////////////////
    // cpu side
    ////////////////////////////////////////
    task automatic run_txn(input logic wr, input logic [31:0] addr, input word_t wdata,
                           input strb_t wstrb, input logic want_hit);
        word_t expected;
        int    latency;
        logic  saw_rd;
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wstrb <= wstrb;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // accepted here
        req_valid <= 1'b0;
        cur_line = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        expected = golden_word(addr);
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) expected[8*b +: 8] = wdata[8*b +: 8];
            end
            golden[addr] = expected;
        end
        latency = 0;
        saw_rd  = 1'b0;
        do begin
            @(negedge clk);
            latency++;
            saw_rd = saw_rd | mem_rd_req;
        end while (!resp_valid);
        if (!wr) compare("rdata", expected, rdata);
        if (want_hit) begin
            compare("hit latency", 2, latency);
            compare("mem_rd_req on hit", '0, saw_rd);
        end
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] last_addr;
        logic        last_write;
        logic        wr;
        logic        want_hit;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        last_addr  = '0;
        last_write = 1'b0;
        cur_line   = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare("req_ready", 1, req_ready);
        compare("resp_valid", '0, resp_valid);
        compare("mem_rd_req", '0, mem_rd_req);
        compare("mem_wr_req", '0, mem_wr_req);
        @(posedge clk);
        for (int i = 0; i < NUM_TXN; i++) begin
            r        = next_random();
            want_hit = 1'b0;
            if (i > 0 && r[2:0] == 3'd0) begin
                // same line again so it has to hit
                addr     = {last_addr[31:4], r[9:8], 2'b00};
                wr       = 1'b0;
                want_hit = 1'b1;
            end else if (last_write && r[4:3] != 2'd0) begin
                addr = last_addr;  // read the stored word back
                wr   = 1'b0;
            end else begin
                // 4 tags over 4 sets
                addr = 32'h0004_0000 | (32'(r[11:10]) << 12) | (32'(r[13:12]) << 4)
                       | (32'(r[15:14]) << 2);
                wr   = r[16];
            end
            run_txn(wr, addr, next_random(), r[23:20], want_hit);
            last_addr  = addr;
            last_write = wr;
        end
        repeat (4) @(posedge clk);
        compare("resp_valid count", NUM_TXN, resp_count);
        errors += u_dut.u_assertions.fail_count;
        $display("errors: %0d, responses: %0d of %0d transactions",
                 errors, resp_count, NUM_TXN);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/dcache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input wire                           clk,
    input wire                           reset,
    input wire                           req_ready,
    input wire                           resp_valid,
    input wire                           mem_rd_req,
    input wire                           mem_rd_rdy,
    input wire [dcache_pkg::ADDR_W-1:0]  mem_rd_addr,
    input wire                           mem_wr_req,
    input wire                           mem_wr_rdy,
    input wire [dcache_pkg::ADDR_W-1:0]  mem_wr_addr,
    input wire dcache_pkg::line_t        mem_wr_data
);
    int fail_count = 0;

    a_one_request: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req))
        else begin
            fail_count++;
            $error("read and write requests raised together");
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr))
        else begin
            fail_count++;
            $error("read request dropped or changed before rdy");
        end

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=>
            mem_wr_req && $stable(mem_wr_addr) && $stable(mem_wr_data))
        else begin
            fail_count++;
            $error("write request dropped or changed before rdy");
        end

    // response is a single cycle pulse
    a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
        else begin
            fail_count++;
            $error("resp_valid longer than one cycle");
        end

    a_busy: assert property (@(posedge clk) disable iff (reset)
        (mem_rd_req || mem_wr_req) |-> !req_ready)
        else begin
            fail_count++;
            $error("req_ready high during a memory request");
        end

endmodule

bind dcache_top dcache_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .mem_rd_req  (mem_rd_req),
    .mem_rd_rdy  (mem_rd_rdy),
    .mem_rd_addr (mem_rd_addr),
    .mem_wr_req  (mem_wr_req),
    .mem_wr_rdy  (mem_wr_rdy),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data)
);

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int NUM_SETS = 16
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               req_valid,
    input  wire                               req_write,
    input  wire [dcache_pkg::ADDR_W-1:0]      req_addr,
    input  wire dcache_pkg::word_t            req_wdata,
    input  wire dcache_pkg::strb_t            req_wstrb,
    output logic                              req_ready,
    output logic                              resp_valid,
    output dcache_pkg::word_t                 rdata,
    output logic                              mem_rd_req,
    output logic [dcache_pkg::ADDR_W-1:0]     mem_rd_addr,
    input  wire                               mem_rd_rdy,
    input  wire                               mem_ret_valid,
    input  wire dcache_pkg::line_t            mem_ret_data,
    output logic                              mem_wr_req,
    output logic [dcache_pkg::ADDR_W-1:0]     mem_wr_addr,
    output dcache_pkg::line_t                 mem_wr_data,
    input  wire                               mem_wr_rdy
);
    import dcache_pkg::*;

    line_t                              merge_base;
    line_t                              merged_line;
    logic [$clog2(WORDS_PER_LINE)-1:0]  merge_word_sel;
    word_t                              merge_wdata;
    strb_t                              merge_wstrb;

    line_store_if #(.NUM_SETS(NUM_SETS)) store_bus ();

    dcache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_wstrb      (req_wstrb),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .rdata          (rdata),
        .mem_rd_req     (mem_rd_req),
        .mem_rd_addr    (mem_rd_addr),
        .mem_rd_rdy     (mem_rd_rdy),
        .mem_ret_valid  (mem_ret_valid),
        .mem_ret_data   (mem_ret_data),
        .mem_wr_req     (mem_wr_req),
        .mem_wr_addr    (mem_wr_addr),
        .mem_wr_data    (mem_wr_data),
        .mem_wr_rdy     (mem_wr_rdy),
        .merge_base     (merge_base),
        .merge_word_sel (merge_word_sel),
        .merge_wdata    (merge_wdata),
        .merge_wstrb    (merge_wstrb),
        .merged_line    (merged_line),
        .bus            (store_bus.ctrl)
    );

    store_merge u_merge (
        .base_line   (merge_base),
        .word_sel    (merge_word_sel),
        .wdata       (merge_wdata),
        .wstrb       (merge_wstrb),
        .merged_line (merged_line)
    );

    cache_storage #(.NUM_SETS(NUM_SETS)) u_storage (
        .clk   (clk),
        .reset (reset),
        .bus   (store_bus.store)
    );

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int NUM_SETS = 16
) (
    input  wire                                          clk,
    input  wire                                          reset,
    // cpu side
    input  wire                                          req_valid,
    input  wire                                          req_write,
    input  wire [dcache_pkg::ADDR_W-1:0]                 req_addr,
    input  wire dcache_pkg::word_t                       req_wdata,
    input  wire dcache_pkg::strb_t                       req_wstrb,
    output logic                                         req_ready,
    output logic                                         resp_valid,
    output dcache_pkg::word_t                            rdata,
    // memory side
    output logic                                         mem_rd_req,
    output logic [dcache_pkg::ADDR_W-1:0]                mem_rd_addr,
    input  wire                                          mem_rd_rdy,
    input  wire                                          mem_ret_valid,
    input  wire dcache_pkg::line_t                       mem_ret_data,
    output logic                                         mem_wr_req,
    output logic [dcache_pkg::ADDR_W-1:0]                mem_wr_addr,
    output dcache_pkg::line_t                            mem_wr_data,
    input  wire                                          mem_wr_rdy,
    // merge unit
    output dcache_pkg::line_t                            merge_base,
    output logic [$clog2(dcache_pkg::WORDS_PER_LINE)-1:0] merge_word_sel,
    output dcache_pkg::word_t                            merge_wdata,
    output dcache_pkg::strb_t                            merge_wstrb,
    input  wire dcache_pkg::line_t                       merged_line,
    // tag/data storage
    line_store_if.ctrl                                   bus
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SEL_W   = $clog2(WORDS_PER_LINE);

    cache_state_t        state_q;
    cache_state_t        state_d;
    logic                accept;
    logic                store_hit;
    logic                refill;
    logic                hit_resp_q;
    word_t               hit_word_q;

    // request buffer
    logic                buf_write;
    logic [ADDR_W-1:0]   buf_addr;
    word_t               buf_wdata;
    strb_t               buf_wstrb;
    logic [TAG_W-1:0]    buf_tag;
    logic [INDEX_W-1:0]  buf_index;
    logic [SEL_W-1:0]    buf_sel;

    assign req_ready = (state_q == IDLE);
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_write <= req_write;
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    assign buf_tag   = buf_addr[ADDR_W-1 -: TAG_W];
    assign buf_index = buf_addr[OFFSET_W +: INDEX_W];
    assign buf_sel   = buf_addr[OFFSET_W-1 -: SEL_W];

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:        if (accept) state_d = LOOKUP;
            LOOKUP: begin
                if (bus.hit) begin
                    state_d = IDLE;
                end else if (bus.victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITEBACK:   if (mem_wr_rdy) state_d = REFILL_REQ;
            REFILL_REQ:  if (mem_rd_rdy) state_d = REFILL_WAIT;
            REFILL_WAIT: if (mem_ret_valid) state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= IDLE;
            hit_resp_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            hit_resp_q <= (state_q == LOOKUP) && bus.hit;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            hit_word_q <= bus.hit_line[buf_sel];
        end
    end

    ////////////////////////////////////////
    // storage access
    ////////////////////////////////////////
    assign store_hit = (state_q == LOOKUP) && bus.hit && buf_write;
    assign refill    = (state_q == REFILL_WAIT) && mem_ret_valid;

    // incoming address while idle so the arrays are ready in LOOKUP
    assign bus.index      = (state_q == IDLE) ? req_addr[OFFSET_W +: INDEX_W] : buf_index;
    assign bus.lookup_tag = buf_tag;
    assign bus.wr_en      = store_hit || refill;
    assign bus.wr_way     = (state_q == LOOKUP) ? bus.hit_way : bus.victim_way;
    assign bus.wr_line    = buf_write ? merged_line : mem_ret_data;
    assign bus.wr_dirty   = buf_write;

    assign merge_base     = (state_q == LOOKUP) ? bus.hit_line : mem_ret_data;
    assign merge_word_sel = buf_sel;
    assign merge_wdata    = buf_wdata;
    assign merge_wstrb    = buf_wstrb;

    // hits answer a cycle late, refills in the return cycle
    assign resp_valid = hit_resp_q || refill;
    assign rdata      = hit_resp_q ? hit_word_q : mem_ret_data[buf_sel];

    ////////////////////////////////////////
    // memory port
    ////////////////////////////////////////
    assign mem_wr_req  = (state_q == WRITEBACK);
    assign mem_wr_addr = {bus.victim_tag, buf_index, {OFFSET_W{1'b0}}};
    assign mem_wr_data = bus.victim_line;
    assign mem_rd_req  = (state_q == REFILL_REQ);
    assign mem_rd_addr = {buf_tag, buf_index, {OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- hdl/store_merge.sv
`timescale 1ns/1ps
`default_nettype none

// byte-strobed store into one word of a line
module store_merge (
    input  wire dcache_pkg::line_t                                base_line,
    input  wire [$clog2(dcache_pkg::WORDS_PER_LINE)-1:0]          word_sel,
    input  wire dcache_pkg::word_t                                wdata,
    input  wire dcache_pkg::strb_t                                wstrb,
    output dcache_pkg::line_t                                     merged_line
);
    import dcache_pkg::*;

    always_comb begin
        merged_line = base_line;
        for (int b = 0; b < WORD_W/8; b++) begin
            if (wstrb[b]) begin
                merged_line[word_sel][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/cache_storage.sv
`timescale 1ns/1ps
`default_nettype none

module cache_storage #(
    parameter int NUM_SETS = 16
) (
    input  wire          clk,
    input  wire          reset,
    line_store_if.store  bus
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    logic [INDEX_W-1:0]           idx_q;   // set the RAM outputs belong to
    logic [1:0][TAG_W-1:0]        tag_rd;
    line_t [1:0]                  line_rd;
    logic [NUM_SETS-1:0][1:0]     valid_q;
    logic [NUM_SETS-1:0][1:0]     dirty_q;
    logic [NUM_SETS-1:0]          victim_q;
    logic [1:0]                   hit_vec;
    logic                         hit;
    logic                         victim_way;

    ////////////////////////////////////////
    // tag and data arrays, one pair per way
    ////////////////////////////////////////
    for (genvar w = 0; w < 2; w++) begin : g_way
        logic way_we;

        assign way_we = bus.wr_en && (bus.wr_way == 1'(w));

        cache_ram #(
            .entry_t (logic [TAG_W-1:0]),
            .DEPTH   (NUM_SETS)
        ) u_tag_ram (
            .clk   (clk),
            .we    (way_we),
            .addr  (bus.index),
            .wdata (bus.lookup_tag),
            .rdata (tag_rd[w])
        );

        cache_ram #(
            .entry_t (line_t),
            .DEPTH   (NUM_SETS)
        ) u_data_ram (
            .clk   (clk),
            .we    (way_we),
            .addr  (bus.index),
            .wdata (bus.wr_line),
            .rdata (line_rd[w])
        );

        assign hit_vec[w] = valid_q[idx_q][w] && (tag_rd[w] == bus.lookup_tag);
    end

    always_ff @(posedge clk) begin
        idx_q <= bus.index;
    end

    ////////////////////////////////////////
    // state bits per set
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            victim_q <= '0;
        end else if (bus.wr_en) begin
            valid_q[bus.index][bus.wr_way] <= 1'b1;
            dirty_q[bus.index][bus.wr_way] <= bus.wr_dirty;
            // a write that is not a hit can only be a refill
            if (!hit) begin
                victim_q[bus.index] <= ~victim_q[bus.index];
            end
        end
    end

    // empty way first, then round robin
    always_comb begin
        if (!valid_q[idx_q][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[idx_q][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = victim_q[idx_q];
        end
    end

    assign hit              = |hit_vec;
    assign bus.hit          = hit;
    assign bus.hit_way      = hit_vec[1];
    assign bus.hit_line     = hit_vec[1] ? line_rd[1] : line_rd[0];
    assign bus.victim_way   = victim_way;
    assign bus.victim_dirty = dirty_q[idx_q][victim_way];
    assign bus.victim_tag   = tag_rd[victim_way];
    assign bus.victim_line  = line_rd[victim_way];

endmodule

`default_nettype wire

//--- hdl/line_store_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_store_if #(
    parameter int NUM_SETS = 16
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    // controller side
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   lookup_tag;
    logic               wr_en;
    logic               wr_way;
    line_t              wr_line;
    logic               wr_dirty;

    // storage side follows index by one cycle
    logic               hit;
    logic               hit_way;
    line_t              hit_line;
    logic               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    line_t              victim_line;

    modport ctrl (
        output index, lookup_tag, wr_en, wr_way, wr_line, wr_dirty,
        input  hit, hit_way, hit_line, victim_way, victim_dirty, victim_tag, victim_line
    );

    modport store (
        input  index, lookup_tag, wr_en, wr_way, wr_line, wr_dirty,
        output hit, hit_way, hit_line, victim_way, victim_dirty, victim_tag, victim_line
    );

endinterface

`default_nettype wire

//--- hdl/cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single port, read data registered
module cache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16
) (
    input  wire                       clk,
    input  wire                       we,
    input  wire [$clog2(DEPTH)-1:0]   addr,
    input  wire entry_t               wdata,
    output entry_t                    rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // old contents on a write cycle
    end

endmodule

`default_nettype wire

//--- hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 4;   // byte offset within a line
    localparam int ADDR_W         = 32;

    ////////////////////////////////////////
    // payload types
    ////////////////////////////////////////
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W/8-1:0] strb_t;

    // word 0 sits in the low bits of the line
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,    // dirty victim out to memory
        REFILL_REQ,   // read address phase
        REFILL_WAIT   // waiting for the line
    } cache_state_t;

endpackage

`default_nettype wire
